// ==== logic/fetch_defs.svh ====
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// PC after reset, unaligned so the first block carries two slots
`define FETCH_RESET_PC 32'h1c00_0008

// 32-bit words per icache block
`define FETCH_SLOTS 4

// Instruction buffer entries, power of two and at least 4
`define IB_DEPTH 16

// log2 of IB_DEPTH
`define IB_PTR_W 4

`endif

// ==== logic/fetch_pkg.sv ====
package fetch_pkg;

  // One fetched instruction with its address
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
  } fetch_entry_t;

  // Align stage FSM
  typedef enum logic [1:0] {
    ALIGN_IDLE = 2'd0,  // Ready for a new block
    ALIGN_WAIT = 2'd1,  // Request outstanding
    ALIGN_HOLD = 2'd2,  // Store buffer occupied
    ALIGN_DROP = 2'd3   // Flushed request still in flight
  } align_state_e;

endpackage

// ==== logic/fetch_pc_gen.sv ====
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_pc_gen (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        redirect,
  input  logic [31:0] redirect_pc,
  input  logic        align_ready,
  output logic        icache_req,
  output logic [31:0] icache_addr,
  output logic        req_valid,
  output logic [31:0] req_pc
);

  logic [31:0] pc;
  logic [31:0] block_base;
  logic [31:0] next_block;
  logic        issue;

  assign block_base = {pc[31:4], 4'b0000};
  assign next_block = block_base + 32'd16;

  // Redirect wins over a new request
  assign issue = align_ready && !redirect;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      pc <= `FETCH_RESET_PC;
    end
    else if (redirect)
    begin
      pc <= redirect_pc;  // Target may be unaligned
    end
    else if (issue)
    begin
      pc <= next_block;
    end
  end

  assign icache_req  = issue;
  assign icache_addr = block_base;

  // Align stage needs the full PC for the word offset
  assign req_valid = issue;
  assign req_pc    = pc;

  a_req_aligned: assert property (
    @(posedge clk) disable iff (!arst_n)
    icache_req |-> (icache_addr[3:0] == 4'h0)
  ) else $error("icache request address not block aligned");

endmodule

// ==== logic/fetch_align.sv ====
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_align (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic                           redirect,
  input  logic                           req_valid,
  input  logic [31:0]                    req_pc,
  input  logic                           icache_data_ok,
  input  logic [127:0]                   icache_rdata,
  input  logic [`IB_PTR_W:0]             free_count,
  output logic                           align_ready,
  output logic [2:0]                     push_num,
  output fetch_pkg::fetch_entry_t [3:0]  push_entries
);

  import fetch_pkg::*;

  localparam int CNT_W = `IB_PTR_W + 1;

  align_state_e       state;
  align_state_e       state_nxt;
  logic [31:0]        pc_q;
  logic [1:0]         word_off;
  logic [2:0]         blk_num;
  logic               blk_fits;
  logic               capture;
  fetch_entry_t [3:0] blk_entries;
  fetch_entry_t [3:0] sbuf;

  // Request PC, only written in ALIGN_IDLE
  always_ff @(posedge clk)
  begin
    if (req_valid)
    begin
      pc_q <= req_pc;
    end
  end

  assign word_off = pc_q[3:2];
  assign blk_num  = 3'd4 - {1'b0, word_off};
  assign blk_fits = free_count >= CNT_W'(blk_num);

  // Rotate so the slot at the PC offset lands in entry 0
  always_comb
  begin
    logic [1:0] slot;
    slot = word_off;
    for (int i = 0; i < `FETCH_SLOTS; i++)
    begin
      slot = word_off + 2'(i);  // Wraps, upper entries unused
      blk_entries[i].pc    = pc_q + 32'(4 * i);
      blk_entries[i].instr = icache_rdata[32 * slot +: 32];
    end
  end

  always_comb
  begin
    state_nxt = state;
    case (state)
      ALIGN_IDLE:
      begin
        if (req_valid)
          state_nxt = ALIGN_WAIT;
      end
      ALIGN_WAIT:
      begin
        if (icache_data_ok)
          state_nxt = (redirect || blk_fits) ? ALIGN_IDLE : ALIGN_HOLD;
        else if (redirect)
          state_nxt = ALIGN_DROP;
      end
      ALIGN_HOLD:
      begin
        if (redirect || blk_fits)
          state_nxt = ALIGN_IDLE;  // Flush empties the store buffer
      end
      default:
      begin
        if (icache_data_ok)
          state_nxt = ALIGN_IDLE;  // Stale block thrown away
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      state <= ALIGN_IDLE;
    else
      state <= state_nxt;
  end

  // No room for the block on arrival
  assign capture = (state == ALIGN_WAIT) && icache_data_ok && !redirect && !blk_fits;

  always_ff @(posedge clk)
  begin
    if (capture)
    begin
      sbuf <= blk_entries;
    end
  end

  always_comb
  begin
    push_num = 3'd0;
    if (!redirect && blk_fits)
    begin
      if ((state == ALIGN_HOLD) || ((state == ALIGN_WAIT) && icache_data_ok))
        push_num = blk_num;
    end
  end

  assign push_entries = (state == ALIGN_HOLD) ? sbuf : blk_entries;
  assign align_ready  = (state == ALIGN_IDLE);

  a_push_room: assert property (
    @(posedge clk) disable iff (!arst_n)
    CNT_W'(push_num) <= free_count
  ) else $error("push larger than instruction buffer room");

  a_resp_expected: assert property (
    @(posedge clk) disable iff (!arst_n)
    icache_data_ok |-> (state inside {ALIGN_WAIT, ALIGN_DROP})
  ) else $error("icache response with no request outstanding");

endmodule

// ==== logic/instr_buffer.sv ====
`timescale 1ns/1ps
`include "fetch_defs.svh"

module instr_buffer (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          redirect,
  input  logic [2:0]                    push_num,
  input  fetch_pkg::fetch_entry_t [3:0] push_entries,
  input  logic                          decode_ready,
  output logic [`IB_PTR_W:0]            free_count,
  output logic                          instr_valid,
  output fetch_pkg::fetch_entry_t       instr_entry
);

  import fetch_pkg::*;

  localparam int PTR_W = `IB_PTR_W;
  localparam int CNT_W = `IB_PTR_W + 1;

  fetch_entry_t     mem [`IB_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             pop;

  assign pop = instr_valid && decode_ready;

  // Up to four consecutive writes from wr_ptr
  always_ff @(posedge clk)
  begin
    for (int i = 0; i < `FETCH_SLOTS; i++)
    begin
      if (3'(i) < push_num)
      begin
        mem[wr_ptr + PTR_W'(i)] <= push_entries[i];
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else if (redirect)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      wr_ptr <= wr_ptr + PTR_W'(push_num);  // Pointer wraps at depth
      if (pop)
        rd_ptr <= rd_ptr + PTR_W'(1);
      count <= count + CNT_W'(push_num) - CNT_W'(pop);
    end
  end

  // Room counted at the start of the cycle
  assign free_count  = CNT_W'(`IB_DEPTH) - count;
  assign instr_valid = (count != '0);
  assign instr_entry = mem[rd_ptr];

  a_no_overflow: assert property (
    @(posedge clk) disable iff (!arst_n)
    CNT_W'(push_num) <= free_count
  ) else $error("instruction buffer overflow");

endmodule

// ==== logic/fetch_top.sv ====
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_top (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    redirect,
  input  logic [31:0]             redirect_pc,
  output logic                    icache_req,
  output logic [31:0]             icache_addr,
  input  logic                    icache_data_ok,
  input  logic [127:0]            icache_rdata,
  input  logic                    decode_ready,
  output logic                    instr_valid,
  output fetch_pkg::fetch_entry_t instr_entry
);

  import fetch_pkg::*;

  logic               req_valid;
  logic [31:0]        req_pc;
  logic               align_ready;
  logic [2:0]         push_num;
  fetch_entry_t [3:0] push_entries;
  logic [`IB_PTR_W:0] free_count;

  // IF0
  fetch_pc_gen u_pc_gen (
    .clk         (clk),
    .arst_n      (arst_n),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .align_ready (align_ready),
    .icache_req  (icache_req),
    .icache_addr (icache_addr),
    .req_valid   (req_valid),
    .req_pc      (req_pc)
  );

  // IF1
  fetch_align u_align (
    .clk            (clk),
    .arst_n         (arst_n),
    .redirect       (redirect),
    .req_valid      (req_valid),
    .req_pc         (req_pc),
    .icache_data_ok (icache_data_ok),
    .icache_rdata   (icache_rdata),
    .free_count     (free_count),
    .align_ready    (align_ready),
    .push_num       (push_num),
    .push_entries   (push_entries)
  );

  instr_buffer u_ibuf (
    .clk          (clk),
    .arst_n       (arst_n),
    .redirect     (redirect),
    .push_num     (push_num),
    .push_entries (push_entries),
    .decode_ready (decode_ready),
    .free_count   (free_count),
    .instr_valid  (instr_valid),
    .instr_entry  (instr_entry)
  );

endmodule

// ==== tb/fetch_top_tb.sv ====
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_top_tb;

  import fetch_pkg::*;

  localparam int ROWS = 8;

  typedef struct {
    string       name;
    bit          has_target;
    logic [31:0] target;
    int          count;       // Instructions to accept
    int          delay;       // Cycles before redirect, 0 for none
    bit          rand_ready;
    logic [31:0] first_pc;    // First pc expected after the redirect
  } row_t;

  logic         clk;
  logic         arst_n;
  logic         redirect;
  logic [31:0]  redirect_pc;
  logic         icache_req;
  logic [31:0]  icache_addr;
  logic         icache_data_ok;
  logic [127:0] icache_rdata;
  logic         decode_ready;
  logic         instr_valid;
  fetch_entry_t instr_entry;

  row_t        rows [ROWS];
  bit          table_ready;
  logic [31:0] lcg_state;
  bit          pend;         // Icache response still owed
  logic [31:0] pend_addr;
  int          pend_cnt;
  logic [31:0] exp_pc;
  int          accepted;
  int          errors;
  bit          after_reset;
  int          flush_wait;

  fetch_top dut (
    .clk            (clk),
    .arst_n         (arst_n),
    .redirect       (redirect),
    .redirect_pc    (redirect_pc),
    .icache_req     (icache_req),
    .icache_addr    (icache_addr),
    .icache_data_ok (icache_data_ok),
    .icache_rdata   (icache_rdata),
    .decode_ready   (decode_ready),
    .instr_valid    (instr_valid),
    .instr_entry    (instr_entry)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Program image, each word depends on its own address
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] x;
    x = addr ^ 32'h5a5a_0000;
    return {x[28:0], x[31:29]};
  endfunction

  function automatic logic [127:0] mem_block(input logic [31:0] base);
    logic [127:0] blk;
    for (int k = 0; k < 4; k++)
      blk[32 * k +: 32] = mem_word(base + 32'(4 * k));
    return blk;
  endfunction

  task automatic stop_run();
    errors++;
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic protocol_error(input string msg);
    $display("Protocol error: %s", msg);
    stop_run();
  endtask

  task automatic check_entry(input string name, input fetch_entry_t exp_e,
                             input fetch_entry_t act_e);
    if (exp_e !== act_e)
    begin
      $display("Mismatch in %s: expected pc=%h instr=%h, actual pc=%h instr=%h",
               name, exp_e.pc, exp_e.instr, act_e.pc, act_e.instr);
      stop_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp_b, input logic act_b);
    if (exp_b !== act_b)
    begin
      $display("Mismatch in %s: expected %b, actual %b", name, exp_b, act_b);
      stop_run();
    end
  endtask

  task automatic check_addr(input string name, input logic [31:0] exp_a,
                            input logic [31:0] act_a);
    if (exp_a !== act_a)
    begin
      $display("Mismatch in %s: expected %h, actual %h", name, exp_a, act_a);
      stop_run();
    end
  endtask

  task automatic load_table();
    rows[0] = '{"reset_seq", 1'b0, 32'h0, 12, 0, 1'b0, `FETCH_RESET_PC};
    rows[1] = '{"offset1_seq", 1'b1, 32'h2000_0104, 14, 0, 1'b0, 32'h2000_0104};
    rows[2] = '{"offset2_seq", 1'b1, 32'h2000_0208, 14, 0, 1'b0, 32'h2000_0208};
    rows[3] = '{"offset3_seq", 1'b1, 32'h3000_000c, 14, 0, 1'b0, 32'h3000_000c};
    rows[4] = '{"backpressure", 1'b1, 32'h4000_0004, 60, 0, 1'b1, 32'h4000_0004};
    rows[5] = '{"redirect_wait", 1'b1, 32'h5000_0008, 16, 3, 1'b0, 32'h5000_0008};
    rows[6] = '{"redirect_bp", 1'b1, 32'h6000_000c, 40, 5, 1'b1, 32'h6000_000c};
    rows[7] = '{"aligned_bp", 1'b1, 32'h7000_0000, 40, 0, 1'b1, 32'h7000_0000};
  endtask

  function automatic int watchdog_cycles();
    int total;
    total = 0;
    for (int r = 0; r < ROWS; r++)
      total += rows[r].count;
    return total * 12 + 200;
  endfunction

  // Observe at the falling edge, drive the next cycle at the rising edge
  task automatic cycle_step(input string name, input bit do_redirect,
                            input logic [31:0] target, input bit rand_ready);
    logic [31:0]  rnd;
    fetch_entry_t exp_e;
    bit           resp;
    bit           rdy;
    @(negedge clk);
    if (after_reset)
    begin
      check_bit({name, " first cycle valid"}, 1'b0, instr_valid);
      check_bit({name, " first request"}, 1'b1, icache_req);
      check_addr({name, " first address"}, (`FETCH_RESET_PC) & 32'hffff_fff0, icache_addr);
      after_reset = 1'b0;
    end
    if (flush_wait > 0)
    begin
      flush_wait--;
      if (flush_wait == 0)
        check_bit({name, " flush"}, 1'b0, instr_valid);
    end
    if (icache_req)
    begin
      if (icache_addr[3:0] != 4'h0)
        protocol_error("icache request address is not 16-byte aligned");
      if (pend || icache_data_ok)
        protocol_error("icache request issued while a response is still pending");
      rnd       = lcg_next();
      pend      = 1'b1;
      pend_addr = icache_addr;
      pend_cnt  = 1 + int'(rnd[17:16]);  // 1 to 4 cycles
    end
    if (instr_valid && decode_ready)
    begin
      exp_e.pc    = exp_pc;
      exp_e.instr = mem_word(exp_pc);
      check_entry(name, exp_e, instr_entry);
      exp_pc = exp_pc + 32'd4;
      accepted++;
    end
    resp = 1'b0;
    if (pend)
    begin
      pend_cnt--;
      if (pend_cnt == 0)
      begin
        resp = 1'b1;
        pend = 1'b0;
      end
    end
    rnd = lcg_next();
    rdy = rand_ready ? rnd[20] : 1'b1;
    if (do_redirect)
      rdy = 1'b0;  // No decode in a flush cycle
    @(posedge clk);
    redirect       <= do_redirect;
    redirect_pc    <= do_redirect ? target : 32'h0;
    icache_data_ok <= resp;
    icache_rdata   <= resp ? mem_block(pend_addr) : '0;
    decode_ready   <= rdy;
    if (do_redirect)
      flush_wait = 2;
  endtask

  task automatic run_row(input row_t row);
    int waited;
    int start;
    waited = 0;
    if (row.has_target)
    begin
      // Land the redirect in ALIGN_WAIT, well before the response
      while (row.delay > 0 && (waited < row.delay || !pend || pend_cnt < 2))
      begin
        cycle_step(row.name, 1'b0, 32'h0, row.rand_ready);
        waited++;
      end
      cycle_step(row.name, 1'b1, row.target, row.rand_ready);
      exp_pc = row.first_pc;
    end
    start = accepted;
    while (accepted - start < row.count)
      cycle_step(row.name, 1'b0, 32'h0, row.rand_ready);
  endtask

  initial
  begin
    arst_n         = 1'b0;
    redirect       = 1'b0;
    redirect_pc    = 32'h0;
    icache_data_ok = 1'b0;
    icache_rdata   = '0;
    decode_ready   = 1'b0;
    lcg_state      = 32'd49;
    pend           = 1'b0;
    pend_addr      = 32'h0;
    pend_cnt       = 0;
    accepted       = 0;
    errors         = 0;
    flush_wait     = 0;
    after_reset    = 1'b0;
    load_table();
    exp_pc      = rows[0].first_pc;
    table_ready = 1'b1;
    repeat (3)
    begin
      @(negedge clk);
      check_bit("reset", 1'b0, instr_valid);
    end
    @(posedge clk);
    arst_n       <= 1'b1;
    decode_ready <= 1'b1;
    after_reset = 1'b1;
    for (int r = 0; r < ROWS; r++)
      run_row(rows[r]);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

  initial
  begin
    int limit;
    wait (table_ready);
    limit = watchdog_cycles();
    repeat (limit) @(posedge clk);
    $display("Timeout: the instruction stream did not finish within %0d cycles", limit);
    $display("Regression failed");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== fetch_top.f ====
+incdir+logic
logic/fetch_pkg.sv
logic/fetch_pc_gen.sv
logic/fetch_align.sv
logic/instr_buffer.sv
logic/fetch_top.sv
tb/fetch_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module fetch_top_tb -Mdir obj_dir -o fetch_top_sim -f fetch_top.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/fetch_top_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "Regression passed"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
